//--- hw/corePkg.sv
package corePkg;

    localparam int AddrW = 32;
    localparam int DataW = 32;

    // instruction field widths
    localparam int OpcodeW = 7;
    localparam int RegW = 5;
    localparam int Funct3W = 3;

    typedef enum logic [OpcodeW-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcodeE;

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        WAIT,
        HOLD_BJ,
        STALL
    } fetchStateE;

    typedef enum logic {
        READY,
        MEM_WAIT
    } execStateE;

    typedef struct packed {
        logic             valid;
        logic             write;
        logic [AddrW-1:0] addr;
        logic [DataW-1:0] wdata;
    } memReqT;

    typedef struct packed {
        logic             valid;
        logic [DataW-1:0] rdata;
    } memRspT;

    typedef struct packed {
        logic             valid;
        logic [AddrW-1:0] pc;
        logic [DataW-1:0] inst;
    } fetchOutT;

    // one redirect for both jump and branch
    typedef struct packed {
        logic             valid;
        logic [AddrW-1:0] target;
    } redirectT;

    typedef struct packed {
        logic             valid;
        logic [AddrW-1:0] pc;
        logic [RegW-1:0]  rd;
        logic [DataW-1:0] value;
    } retireT;

endpackage

//--- hw/fetchUnit.sv
`timescale 1ns/1ns

module fetchUnit import corePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  logic     stall,
    input  redirectT redirect,
    output memReqT   fetchReq,
    input  logic     fetchGnt,
    input  memRspT   fetchRsp,
    output fetchOutT fetchOut
);

    fetchStateE state;
    logic [AddrW-1:0] pc;
    logic deliver;
    logic deliverBJ;

    // request stays up for the whole REQ state
    always_comb begin
        fetchReq.valid = (state == REQ);
        fetchReq.write = 1'b0;
        fetchReq.addr = pc;
        fetchReq.wdata = '0;
    end

    // instruction goes to execute now, either fresh or from the stall buffer
    always_comb begin
        deliver = 1'b0;
        deliverBJ = 1'b0;
        if (state == WAIT && fetchRsp.valid && !stall) begin
            deliver = 1'b1;
            deliverBJ = fetchRsp.rdata[6];
        end else if (state == STALL && !stall) begin
            deliver = 1'b1;
            deliverBJ = fetchOut.inst[6];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            pc <= '0;
            fetchOut <= '0;
        end else begin
            fetchOut.valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        pc <= '0;
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (fetchGnt) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (fetchRsp.valid) begin
                        fetchOut.pc <= pc;
                        fetchOut.inst <= fetchRsp.rdata;
                        if (stall) begin
                            state <= STALL;
                        end
                    end
                end
                HOLD_BJ: begin
                    if (redirect.valid) begin
                        pc <= redirect.target;
                        state <= REQ;
                    end
                end
                default: begin
                    // STALL keeps the captured word until stall drops
                    state <= STALL;
                end
            endcase

            if (deliver) begin
                fetchOut.valid <= 1'b1;
                if (deliverBJ) begin
                    state <= HOLD_BJ;
                end else begin
                    pc <= pc + 4;
                    state <= REQ;
                end
            end
        end
    end

    // held request may not change before its grant
    assert property (@(posedge clk) disable iff (rst)
        fetchReq.valid && !fetchGnt |=> $stable(fetchReq));

endmodule

//--- hw/execUnit.sv
`timescale 1ns/1ns

module execUnit import corePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  fetchOutT fetchOut,
    output logic     stall,
    output redirectT redirect,
    output memReqT   dataReq,
    input  logic     dataGnt,
    input  memRspT   dataRsp,
    output retireT   retire
);

    execStateE state;
    logic [DataW-1:0] regs [32];

    logic [DataW-1:0] inst;
    opcodeE opcode;
    logic [RegW-1:0] rd;
    logic [RegW-1:0] rs1;
    logic [RegW-1:0] rs2;
    logic [Funct3W-1:0] funct3;
    logic funct7b5;
    logic [DataW-1:0] immI;
    logic [DataW-1:0] immS;
    logic [DataW-1:0] immB;
    logic [DataW-1:0] immJ;
    logic [DataW-1:0] rs1Val;
    logic [DataW-1:0] rs2Val;
    logic [DataW-1:0] aluRes;
    logic aluOk;
    logic brTaken;
    logic isMem;
    logic issue;
    logic [RegW-1:0] loadRd;
    logic [AddrW-1:0] memPc;
    logic wbEn;
    logic [RegW-1:0] wbRd;
    logic [DataW-1:0] wbVal;
    logic retireNow;
    logic [AddrW-1:0] retirePc;

    assign inst = fetchOut.inst;
    assign opcode = opcodeE'(inst[6:0]);
    assign rd = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign funct7b5 = inst[30];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // x0 is hardwired to zero
    assign rs1Val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Val = (rs2 == '0) ? '0 : regs[rs2];

    always_comb begin
        aluRes = '0;
        aluOk = 1'b0;
        if (opcode == OP) begin
            aluOk = 1'b1;
            case (funct3)
                3'b000: aluRes = funct7b5 ? rs1Val - rs2Val : rs1Val + rs2Val;
                3'b100: aluRes = rs1Val ^ rs2Val;
                3'b110: aluRes = rs1Val | rs2Val;
                3'b111: aluRes = rs1Val & rs2Val;
                default: aluOk = 1'b0;
            endcase
        end else if (opcode == OP_IMM && funct3 == 3'b000) begin
            aluOk = 1'b1;
            aluRes = rs1Val + immI;
        end
    end

    // beq and bne only, anything else falls through
    assign brTaken = (funct3 == 3'b000) ? (rs1Val == rs2Val) :
                     (funct3 == 3'b001) ? (rs1Val != rs2Val) : 1'b0;

    assign isMem = (opcode == LOAD) || (opcode == STORE);
    assign issue = (state == READY) && fetchOut.valid;
    assign stall = (state == MEM_WAIT);

    // writes to x0 and non-writing ops retire with rd 0 and value 0
    always_comb begin
        wbEn = 1'b0;
        wbRd = rd;
        wbVal = aluRes;
        if (state == MEM_WAIT) begin
            wbEn = dataRsp.valid && (loadRd != '0);
            wbRd = loadRd;
            wbVal = dataRsp.rdata;
        end else if (issue) begin
            if (opcode == JAL) begin
                wbEn = (rd != '0);
                wbVal = fetchOut.pc + 4;
            end else begin
                wbEn = aluOk && (rd != '0);
            end
        end
    end

    assign retireNow = (issue && !isMem) ||
                       (state == MEM_WAIT && (dataRsp.valid || (dataGnt && dataReq.write)));
    assign retirePc = (state == MEM_WAIT) ? memPc : fetchOut.pc;

    always_ff @(posedge clk) begin
        if (wbEn) begin
            regs[wbRd] <= wbVal;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= READY;
            dataReq <= '0;
            redirect <= '0;
            retire <= '0;
            loadRd <= '0;
            memPc <= '0;
        end else begin
            redirect.valid <= 1'b0;
            retire.valid <= retireNow;
            retire.pc <= retirePc;
            retire.rd <= wbEn ? wbRd : '0;
            retire.value <= wbEn ? wbVal : '0;
            case (state)
                READY: begin
                    if (fetchOut.valid) begin
                        case (opcode)
                            JAL: begin
                                redirect.valid <= 1'b1;
                                redirect.target <= fetchOut.pc + immJ;
                            end
                            BRANCH: begin
                                redirect.valid <= 1'b1;
                                redirect.target <= brTaken ? fetchOut.pc + immB : fetchOut.pc + 4;
                            end
                            LOAD, STORE: begin
                                dataReq.valid <= 1'b1;
                                dataReq.write <= (opcode == STORE);
                                dataReq.addr <= rs1Val + ((opcode == STORE) ? immS : immI);
                                dataReq.wdata <= rs2Val;
                                loadRd <= (opcode == LOAD) ? rd : '0;
                                memPc <= fetchOut.pc;
                                state <= MEM_WAIT;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                default: begin
                    if (dataGnt) begin
                        dataReq.valid <= 1'b0;
                    end
                    // store done at grant, load done at response
                    if (dataRsp.valid || (dataGnt && dataReq.write)) begin
                        state <= READY;
                    end
                end
            endcase
        end
    end

    // fetch has to hold its instruction while a load or store is pending
    assert property (@(posedge clk) disable iff (rst)
        state == MEM_WAIT |-> !fetchOut.valid);

endmodule

//--- hw/memArbiter.sv
`timescale 1ns/1ns

module memArbiter import corePkg::*; #(
    parameter int MemWords = 1024
) (
    input  logic   clk,
    input  logic   rst,
    input  memReqT hostReq,
    input  memReqT dataReq,
    input  memReqT fetchReq,
    output logic   hostGnt,
    output logic   dataGnt,
    output logic   fetchGnt,
    output memRspT hostRsp,
    output memRspT dataRsp,
    output memRspT fetchRsp,
    output memReqT memReq,
    input  memRspT memRsp
);

    // one-hot owner of the read in flight: host, data, fetch
    logic [2:0] rspSel;

    // fixed priority host > data > fetch
    assign hostGnt = hostReq.valid;
    assign dataGnt = dataReq.valid && !hostReq.valid;
    assign fetchGnt = fetchReq.valid && !hostReq.valid && !dataReq.valid;

    always_comb begin
        if (hostGnt) begin
            memReq = hostReq;
        end else if (dataGnt) begin
            memReq = dataReq;
        end else if (fetchGnt) begin
            memReq = fetchReq;
        end else begin
            memReq = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rspSel <= '0;
        end else begin
            rspSel <= (memReq.valid && !memReq.write) ? {fetchGnt, dataGnt, hostGnt} : 3'b000;
        end
    end

    // read data fans out, only the owner sees valid
    always_comb begin
        hostRsp = {memRsp.valid && rspSel[0], memRsp.rdata};
        dataRsp = {memRsp.valid && rspSel[1], memRsp.rdata};
        fetchRsp = {memRsp.valid && rspSel[2], memRsp.rdata};
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({hostGnt, dataGnt, fetchGnt}));

    assert property (@(posedge clk) disable iff (rst)
        memReq.valid |-> (memReq.addr[AddrW-1:2] < MemWords));

endmodule

//--- hw/unifiedMem.sv
`timescale 1ns/1ns

module unifiedMem import corePkg::*; #(
    parameter int MemWords = 1024
) (
    input  logic   clk,
    input  memReqT memReq,
    output memRspT memRsp
);

    localparam int IdxW = $clog2(MemWords);

    logic [DataW-1:0] mem [MemWords];
    logic [IdxW-1:0] idx;

    // word index, byte offset dropped
    assign idx = memReq.addr[IdxW+1:2];

    always_ff @(posedge clk) begin
        if (memReq.valid && memReq.write) begin
            mem[idx] <= memReq.wdata;
        end
    end

    // one cycle read latency, writes give no response
    always_ff @(posedge clk) begin
        memRsp.valid <= memReq.valid && !memReq.write;
        memRsp.rdata <= mem[idx];
    end

endmodule

//--- hw/miniCore.sv
`timescale 1ns/1ns

module miniCore import corePkg::*; #(
    parameter int MemWords = 1024
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  memReqT hostReq,
    output logic   hostGnt,
    output memRspT hostRsp,
    output retireT retire
);

    fetchOutT fetchOut;
    redirectT redirect;
    logic stall;

    memReqT fetchReq;
    logic fetchGnt;
    memRspT fetchRsp;

    memReqT dataReq;
    logic dataGnt;
    memRspT dataRsp;

    memReqT memReq;
    memRspT memRsp;

    fetchUnit u_fetchUnit (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .stall    (stall),
        .redirect (redirect),
        .fetchReq (fetchReq),
        .fetchGnt (fetchGnt),
        .fetchRsp (fetchRsp),
        .fetchOut (fetchOut)
    );

    execUnit u_execUnit (
        .clk      (clk),
        .rst      (rst),
        .fetchOut (fetchOut),
        .stall    (stall),
        .redirect (redirect),
        .dataReq  (dataReq),
        .dataGnt  (dataGnt),
        .dataRsp  (dataRsp),
        .retire   (retire)
    );

    memArbiter #(.MemWords(MemWords)) u_memArbiter (
        .clk      (clk),
        .rst      (rst),
        .hostReq  (hostReq),
        .dataReq  (dataReq),
        .fetchReq (fetchReq),
        .hostGnt  (hostGnt),
        .dataGnt  (dataGnt),
        .fetchGnt (fetchGnt),
        .hostRsp  (hostRsp),
        .dataRsp  (dataRsp),
        .fetchRsp (fetchRsp),
        .memReq   (memReq),
        .memRsp   (memRsp)
    );

    unifiedMem #(.MemWords(MemWords)) u_unifiedMem (
        .clk    (clk),
        .memReq (memReq),
        .memRsp (memRsp)
    );

endmodule

//--- include/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// instruction encoders for the RV32I formats
function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
endfunction

function automatic logic [31:0] encAddi(input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
endfunction

function automatic logic [31:0] encLw(input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
endfunction

function automatic logic [31:0] encSw(input int rs2, input int rs1, input int imm);
    logic [11:0] i;
    i = 12'(imm);
    return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] encBr(input logic [2:0] f3, input int rs1, input int rs2,
                                      input int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
endfunction

function automatic logic [31:0] encJal(input int rd, input int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
endfunction

// every program starts by zeroing x1 to x31
function automatic void clearRegs();
    for (int i = 1; i < 32; i++) begin
        prog.push_back(encAddi(i, 0, 0));
    end
endfunction

`endif

//--- verif/miniCoreTb.sv
`timescale 1ns/1ns

module miniCoreTb import corePkg::*; ();

    logic clk;
    logic rst;
    logic start;
    memReqT hostReq;
    logic hostGnt;
    memRspT hostRsp;
    retireT retire;

    logic [31:0] prog[$];
    logic [31:0] shadow [1024];
    retireT expQ[$];
    int retCount;
    bit checking;
    int errors;

    `include "tbProgram.svh"

    miniCore #(.MemWords(1024)) u_miniCore (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .hostReq (hostReq),
        .hostGnt (hostGnt),
        .hostRsp (hostRsp),
        .retire  (retire)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] fill(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            errors++;
            $display("Mismatch %s exp=%h got=%h", name, exp, got);
        end
    endtask

    // instruction-level model that also applies stores to the shadow memory
    function automatic void refRun();
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] in;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] nextPc;
        logic [31:0] val;
        logic [2:0] f3;
        int rd;
        retireT rec;
        bit done;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        pc = '0;
        done = 0;
        expQ.delete();
        for (int step = 0; step < 5000 && !done; step++) begin
            in = shadow[pc[11:2]];
            a = r[in[19:15]];
            b = r[in[24:20]];
            f3 = in[14:12];
            rd = in[11:7];
            val = '0;
            nextPc = pc + 4;
            case (in[6:0])
                7'b0110011: begin
                    case (f3)
                        3'b000: val = in[30] ? a - b : a + b;
                        3'b100: val = a ^ b;
                        3'b110: val = a | b;
                        3'b111: val = a & b;
                        default: rd = 0;
                    endcase
                end
                7'b0010011: begin
                    if (f3 == 3'b000) val = a + {{20{in[31]}}, in[31:20]};
                    else rd = 0;
                end
                7'b0000011: val = shadow[(a + {{20{in[31]}}, in[31:20]}) >> 2];
                7'b0100011: begin
                    shadow[(a + {{20{in[31]}}, in[31:25], in[11:7]}) >> 2] = b;
                    rd = 0;
                end
                7'b1100011: begin
                    if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
                        nextPc = pc + {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
                    rd = 0;
                end
                7'b1101111: begin
                    val = pc + 4;
                    nextPc = pc + {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
                    done = (nextPc == pc);
                end
                default: rd = 0;
            endcase
            if (rd == 0) val = '0;
            if (rd != 0) r[rd] = val;
            rec = '{valid: 1'b1, pc: pc, rd: 5'(rd), value: val};
            expQ.push_back(rec);
            pc = nextPc;
        end
    endfunction

    task automatic hostAccess(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int t;
        rdata = '0;
        @(negedge clk);
        hostReq = '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
        t = 0;
        @(posedge clk);
        while (!hostGnt && t < 100) begin
            t++;
            @(posedge clk);
        end
        if (!hostGnt) begin
            errors++;
            $display("host request to %h was never granted", addr);
        end
        @(negedge clk);
        hostReq = '0;
        if (!wr) begin
            t = 0;
            while (!hostRsp.valid && t < 20) begin
                t++;
                @(negedge clk);
            end
            if (!hostRsp.valid) begin
                errors++;
                $display("no host read response from %h", addr);
            end
            rdata = hostRsp.rdata;
        end
    endtask

    task automatic hostWrite(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        hostAccess(1'b1, addr, data, unused);
        shadow[addr[11:2]] = data;
    endtask

    task automatic hostCheck(input logic [31:0] addr);
        logic [31:0] got;
        hostAccess(1'b0, addr, '0, got);
        checkVal("hostRsp.rdata", shadow[addr[11:2]], got);
    endtask

    // reset the core, load prog at address 0, build the expected trace
    task automatic loadProg();
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        foreach (prog[i]) begin
            hostWrite(32'(i * 4), prog[i]);
        end
        refRun();
    endtask

    task automatic startAndWait();
        int t;
        retCount = 0;
        checking = 1;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        t = 0;
        while (retCount < expQ.size() && t < 20000) begin
            t++;
            @(negedge clk);
        end
        if (retCount < expQ.size()) begin
            errors++;
            $display("timeout after %0d of %0d retirements", retCount, expQ.size());
        end
        checking = 0;
    endtask

    always @(negedge clk) begin
        if (checking && retire.valid && retCount < expQ.size()) begin
            checkVal("retire.pc", expQ[retCount].pc, retire.pc);
            checkVal("retire.rd", 32'(expQ[retCount].rd), 32'(retire.rd));
            checkVal("retire.value", expQ[retCount].value, retire.value);
            retCount++;
        end
    end

    function automatic void buildRandom(input int n);
        int kind;
        prog.delete();
        clearRegs();
        prog.push_back(encAddi(10, 0, 2047));
        prog.push_back(encAddi(10, 10, 1));
        for (int i = 0; i < n; i++) begin
            kind = $urandom % 6;
            if (kind == 0) begin
                prog.push_back(encAddi($urandom % 10, $urandom % 11, $urandom % 4096));
            end else if (kind == 1) begin
                prog.push_back(encR(($urandom % 2) ? 7'h20 : 7'h00, $urandom % 11,
                                    $urandom % 11, 3'($urandom % 8), $urandom % 10));
            end else if (kind == 2) begin
                prog.push_back(encLw($urandom % 10, 10, ($urandom % 64) * 4));
            end else if (kind == 3) begin
                prog.push_back(encSw($urandom % 11, 10, ($urandom % 64) * 4));
            end else if (kind == 4 && i < n - 2) begin
                prog.push_back(encBr(3'($urandom % 2), $urandom % 11, $urandom % 11,
                                     8 + 4 * ($urandom % 2)));
            end else begin
                prog.push_back(encR(7'h00, $urandom % 11, $urandom % 11, 3'b111, $urandom % 10));
            end
        end
        prog.push_back(encJal(0, 0));
    endfunction

    initial begin
        void'($urandom(32'h7b74_a484));
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        hostReq = '0;
        checking = 0;
        errors = 0;
        retCount = 0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // data region gets an address-dependent pattern
        for (int w = 512; w < 1024; w++) begin
            hostWrite(32'(w * 4), fill(32'(w * 4)));
        end

        // straight-line ALU ops with writes to x0
        prog.delete();
        clearRegs();
        prog.push_back(encAddi(1, 0, 5));
        prog.push_back(encAddi(2, 0, -3));
        prog.push_back(encR(7'h00, 2, 1, 3'b000, 3));
        prog.push_back(encR(7'h20, 2, 1, 3'b000, 4));
        prog.push_back(encR(7'h00, 4, 3, 3'b111, 5));
        prog.push_back(encR(7'h00, 2, 1, 3'b110, 6));
        prog.push_back(encR(7'h00, 1, 6, 3'b100, 7));
        prog.push_back(encAddi(0, 1, 7));
        prog.push_back(encR(7'h00, 1, 1, 3'b000, 0));
        prog.push_back(encAddi(8, 7, 2047));
        prog.push_back(encR(7'h20, 8, 0, 3'b000, 9));
        prog.push_back(encJal(0, 0));
        loadProg();
        startAndWait();

        // stores then loads and a host readback
        prog.delete();
        clearRegs();
        prog.push_back(encAddi(10, 0, 2047));
        prog.push_back(encAddi(10, 10, 1));
        prog.push_back(encAddi(1, 0, 12'h123));
        prog.push_back(encSw(1, 10, 0));
        prog.push_back(encAddi(2, 0, -77));
        prog.push_back(encSw(2, 10, 8));
        prog.push_back(encLw(3, 10, 0));
        prog.push_back(encLw(4, 10, 8));
        prog.push_back(encLw(5, 10, 4));
        prog.push_back(encSw(3, 10, 12));
        prog.push_back(encLw(0, 10, 12));
        prog.push_back(encLw(6, 10, 12));
        prog.push_back(encJal(0, 0));
        loadProg();
        startAndWait();
        hostCheck(32'd2048);
        hostCheck(32'd2056);
        hostCheck(32'd2060);

        // taken and not taken branches and a JAL with link
        prog.delete();
        clearRegs();
        prog.push_back(encAddi(1, 0, 1));
        prog.push_back(encAddi(2, 0, 1));
        prog.push_back(encBr(3'b000, 1, 2, 8));
        prog.push_back(encAddi(3, 0, 99));
        prog.push_back(encBr(3'b001, 1, 2, 8));
        prog.push_back(encAddi(4, 0, 4));
        prog.push_back(encBr(3'b000, 1, 0, 8));
        prog.push_back(encAddi(5, 0, 5));
        prog.push_back(encBr(3'b001, 1, 0, 8));
        prog.push_back(encAddi(6, 0, 66));
        prog.push_back(encJal(7, 8));
        prog.push_back(encAddi(8, 0, 88));
        prog.push_back(encAddi(9, 7, 1));
        prog.push_back(encJal(0, 0));
        loadProg();
        startAndWait();

        // load/store loop while the host reads an untouched region
        prog.delete();
        clearRegs();
        prog.push_back(encAddi(10, 0, 2047));
        prog.push_back(encAddi(10, 10, 1));
        prog.push_back(encAddi(1, 0, 12));
        prog.push_back(encSw(1, 10, 16));
        prog.push_back(encLw(2, 10, 16));
        prog.push_back(encSw(2, 10, 20));
        prog.push_back(encAddi(1, 1, -1));
        prog.push_back(encBr(3'b001, 1, 0, -16));
        prog.push_back(encJal(0, 0));
        loadProg();
        // reads span the whole run so they overlap the data accesses of the loop
        fork
            startAndWait();
            for (int w = 768; w < 1024; w++) begin
                hostCheck(32'(w * 4));
            end
        join

        for (int p = 0; p < 4; p++) begin
            buildRandom(40);
            loadProg();
            startAndWait();
        end

        $display("errors=%0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- miniCore.f
+incdir+include
hw/corePkg.sv
hw/fetchUnit.sv
hw/execUnit.sv
hw/memArbiter.sv
hw/unifiedMem.sv
hw/miniCore.sv
verif/miniCoreTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module miniCoreTb -f miniCore.f -o simv

out=$(./obj_dir/simv)
echo "$out"

# the run passes only if the testbench printed its pass line
echo "$out" | grep -q "^Test OK$"
